/* list.f */
+incdir+verilog
verilog/serial_pkg.sv
verilog/echo_pkg.sv
verilog/serial_rx.sv
verilog/echo_formatter.sv
verilog/serial_tx.sv
verilog/serial_echo_top.sv
sim/serial_echo_checker.sv
sim/tb_serial_echo.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_serial_echo -f list.f \
		-Mdir obj_dir -o tb_serial_echo
	./obj_dir/tb_serial_echo | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_serial_echo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_defs.svh"

module tb_serial_echo;

	localparam int BIT_CLKS = `SERIAL_CLKS_PER_TICK * `SERIAL_OVERSAMPLE;
	localparam int FRAME_CLKS = 11 * BIT_CLKS;
	localparam int DRAIN_TIMEOUT = 30 * FRAME_CLKS;
	localparam int NROWS = 11;

	logic clk27;
	logic rst;
	logic serial_rx;
	wire serial_tx;
	wire parity_error;
	wire overrun;
	// expectations toward the checker
	logic exp_push;
	logic [95:0] exp_line;
	logic flag_check;
	logic parity_exp;
	logic overrun_exp;
	int pending;
	int err_cnt;
	int frames;
	int tb_errors;

	// stimulus table: char, bad parity, back-to-back, echo expected
	serial_pkg::char_t row_char [NROWS];
	bit row_bad [NROWS];
	bit row_b2b [NROWS];
	bit row_echo [NROWS];

	serial_echo_top i_dut (
		.clk27(clk27),
		.rst(rst),
		.serial_rx(serial_rx),
		.serial_tx(serial_tx),
		.parity_error(parity_error),
		.overrun(overrun)
	);

	serial_echo_checker i_chk (
		.clk27(clk27),
		.rst(rst),
		.serial_tx(serial_tx),
		.parity_error(parity_error),
		.overrun(overrun),
		.exp_push(exp_push),
		.exp_line(exp_line),
		.flag_check(flag_check),
		.parity_exp(parity_exp),
		.overrun_exp(overrun_exp),
		.pending(pending),
		.err_cnt(err_cnt),
		.frames(frames)
	);

	// 4 ns period
	always #2 clk27 = ~clk27;

	// char, space, bits msb first, cr, lf
	function automatic logic [95:0] echo_line(input serial_pkg::char_t c);
		logic [95:0] line;
		int k;
		line[7:0] = c;
		line[15:8] = `SERIAL_ASCII_SPACE;
		for (k = 0; k < 8; k++) begin
			line[8*(k+2) +: 8] = c[7-k] ? `SERIAL_ASCII_ONE : `SERIAL_ASCII_ZERO;
		end
		line[87:80] = `SERIAL_ASCII_CR;
		line[95:88] = `SERIAL_ASCII_LF;
		return line;
	endfunction

	function automatic serial_pkg::char_t random_printable();
		return 8'h20 + 8'($urandom % 95);
	endfunction

	task automatic set_row(input int idx, input serial_pkg::char_t c, input bit bad,
			input bit b2b, input bit echo);
		row_char[idx] = c;
		row_bad[idx] = bad;
		row_b2b[idx] = b2b;
		row_echo[idx] = echo;
	endtask

	task automatic load_table();
		set_row(0, 8'h41, 1'b0, 1'b0, 1'b1);
		set_row(1, 8'h00, 1'b0, 1'b0, 1'b1);
		set_row(2, 8'hff, 1'b0, 1'b0, 1'b1);
		set_row(3, random_printable(), 1'b0, 1'b0, 1'b1);
		// bad parity, then a good one
		set_row(4, 8'h5a, 1'b1, 1'b0, 1'b0);
		set_row(5, random_printable(), 1'b0, 1'b0, 1'b1);
		// three in a row, third one lost
		set_row(6, 8'h61, 1'b0, 1'b0, 1'b1);
		set_row(7, 8'h62, 1'b0, 1'b1, 1'b1);
		set_row(8, 8'h63, 1'b0, 1'b1, 1'b0);
		set_row(9, random_printable(), 1'b0, 1'b0, 1'b1);
		set_row(10, random_printable(), 1'b0, 1'b0, 1'b1);
	endtask

	// --------------------
	// line driver
	// --------------------
	task automatic send_frame(input serial_pkg::char_t c, input bit bad, input bit echo);
		logic [10:0] bits;
		int i;
		// stop, parity, data, start, sent from bit 0
		bits = {1'b1, (^c) ^ bad, c, 1'b0};
		for (i = 0; i < 11; i++) begin
			serial_rx <= bits[i];
			if (i == 0) begin
				exp_push <= echo;
				exp_line <= echo_line(c);
			end
			@(posedge clk27);
			exp_push <= 1'b0;
			flag_check <= 1'b0;
			repeat (BIT_CLKS - 1) @(posedge clk27);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk27);
			flag_check <= 1'b0;
		end
	endtask

	// all expected echo bytes seen
	task automatic wait_drain(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < DRAIN_TIMEOUT; n++) begin
			@(posedge clk27);
			flag_check <= 1'b0;
			if (pending == 0) begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	initial begin
		int r;
		bit ok;
		bit aborted;
		bit par_model;
		bit ovr_model;
		clk27 = 1'b0;
		rst = 1'b1;
		serial_rx = 1'b1;
		exp_push = 1'b0;
		exp_line = '0;
		flag_check = 1'b0;
		parity_exp = 1'b0;
		overrun_exp = 1'b0;
		tb_errors = 0;
		aborted = 1'b0;
		par_model = 1'b0;
		ovr_model = 1'b0;
		void'($urandom(3));
		load_table();
		repeat (8) @(posedge clk27);
		rst <= 1'b0;
		idle(16);
		for (r = 0; r < NROWS; r++) begin
			if (!row_b2b[r]) begin
				wait_drain(ok);
				if (!ok) begin
					$display("timeout: echo of earlier characters never finished (row %0d)", r);
					tb_errors++;
					aborted = 1'b1;
					break;
				end
				// random idle gap between frames
				idle(16 + int'($urandom % 400));
			end
			send_frame(row_char[r], row_bad[r], row_echo[r]);
			// flag state after this row
			if (row_bad[r]) begin
				par_model = 1'b1;
			end else if (!row_echo[r]) begin
				ovr_model = 1'b1;
			end
			flag_check <= 1'b1;
			parity_exp <= par_model;
			overrun_exp <= ovr_model;
		end
		if (!aborted) begin
			wait_drain(ok);
			if (!ok) begin
				$display("timeout: expected echo characters are still missing at the end");
				tb_errors++;
			end else begin
				// quiet window, any frame now is extra
				idle(30 * FRAME_CLKS);
			end
		end
		$display("errors: %0d in checks, %0d in testbench, %0d frames decoded",
			err_cnt, tb_errors, frames);
		if (err_cnt == 0 && tb_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/serial_echo_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_defs.svh"

module serial_echo_checker (
	input  wire        clk27,
	input  wire        rst,
	input  wire        serial_tx,
	input  wire        parity_error,
	input  wire        overrun,
	input  wire        exp_push,
	input  wire [95:0] exp_line,
	input  wire        flag_check,
	input  wire        parity_exp,
	input  wire        overrun_exp,
	output int         pending,
	output int         err_cnt,
	output int         frames
);

	localparam int BIT_CLKS = `SERIAL_CLKS_PER_TICK * `SERIAL_OVERSAMPLE;

	// expected echo bytes, oldest first
	serial_pkg::char_t expected[$];
	serial_pkg::char_t data;
	serial_pkg::char_t want;
	serial_pkg::bit_idx_t data_idx;
	logic par;
	logic in_frame;
	logic after_rst;
	logic par_seen;
	logic ovr_seen;
	// clock within bit, bit within frame
	int clk_cnt = 0;
	int pos = 0;
	int errors = 0;
	int frame_cnt = 0;
	int k;

	task automatic value_error(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		$display("Error %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		errors++;
	endtask

	task automatic plain_error(input string what);
		$display("Error %0t ns: %s", $time, what);
		errors++;
	endtask

	// --------------------
	// frame end
	// --------------------
	task automatic close_frame(input logic stop);
		frame_cnt++;
		// even parity over data plus parity bit
		if (par !== ^data) begin
			value_error("output parity bit", {7'b0, par}, {7'b0, ^data});
		end
		if (stop !== 1'b1) begin
			plain_error("stop bit of output frame is not high");
		end
		if (expected.size() == 0) begin
			plain_error($sformatf("unexpected output character 0x%02h", data));
		end else begin
			want = expected.pop_front();
			if (data !== want) begin
				value_error("echo character", data, want);
			end
		end
	endtask

	always @(posedge clk27) begin
		// twelve bytes per push, first byte in the low bits
		if (exp_push) begin
			for (k = 0; k < 12; k++) begin
				expected.push_back(exp_line[8*k +: 8]);
			end
		end
		if (rst) begin
			in_frame = 1'b0;
			after_rst = 1'b1;
			par_seen = 1'b0;
			ovr_seen = 1'b0;
		end else begin
			// line idles high out of reset
			if (after_rst && serial_tx !== 1'b1) begin
				plain_error("serial_tx is not high after reset");
			end
			after_rst = 1'b0;
			// flags are sticky
			if (par_seen && !parity_error) begin
				plain_error("parity_error fell without reset");
			end
			if (ovr_seen && !overrun) begin
				plain_error("overrun fell without reset");
			end
			par_seen = parity_error;
			ovr_seen = overrun;
			if (flag_check) begin
				if (parity_error !== parity_exp) begin
					value_error("parity_error", {7'b0, parity_error}, {7'b0, parity_exp});
				end
				if (overrun !== overrun_exp) begin
					value_error("overrun", {7'b0, overrun}, {7'b0, overrun_exp});
				end
			end
			// --------------------
			// output frame decoder
			// --------------------
			if (!in_frame) begin
				// first low clock is the start bit
				if (!serial_tx) begin
					in_frame = 1'b1;
					clk_cnt = 0;
					pos = 0;
				end
			end else begin
				if (clk_cnt == BIT_CLKS - 1) begin
					clk_cnt = 0;
					pos++;
				end else begin
					clk_cnt++;
				end
				// mid-bit sample
				if (clk_cnt == BIT_CLKS / 2) begin
					if (pos == 0 && serial_tx) begin
						plain_error("start bit of output frame is too short");
						in_frame = 1'b0;
					end else if (pos >= 1 && pos <= 8) begin
						data_idx = serial_pkg::bit_idx_t'(pos - 1);
						data[data_idx] = serial_tx;
					end else if (pos == 9) begin
						par = serial_tx;
					end else if (pos == 10) begin
						close_frame(serial_tx);
						in_frame = 1'b0;
					end
				end
			end
		end
		pending <= expected.size();
		err_cnt <= errors;
		frames <= frame_cnt;
	end

endmodule

`default_nettype wire

/* verilog/serial_echo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_echo_top (
	input  wire clk27,
	input  wire rst,
	input  wire serial_rx,
	output wire serial_tx,
	output wire parity_error,
	output wire overrun
);

	// rx to formatter handshake
	serial_pkg::char_t rx_char;
	logic rx_req;
	logic rx_ack;

	// formatter to tx handshake
	serial_pkg::char_t tx_char;
	logic tx_req;
	logic tx_ack;

	// --------------------
	// input side
	// --------------------
	serial_rx i_rx (
		.clk27(clk27),
		.rst(rst),
		.serial_rx(serial_rx),
		.rx_char(rx_char),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.parity_error(parity_error),
		.overrun(overrun)
	);

	// one char in, twelve chars out
	echo_formatter i_fmt (
		.clk27(clk27),
		.rst(rst),
		.rx_char(rx_char),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.tx_char(tx_char),
		.tx_req(tx_req),
		.tx_ack(tx_ack)
	);

	// --------------------
	// output side
	// --------------------
	serial_tx i_tx (
		.clk27(clk27),
		.rst(rst),
		.tx_char(tx_char),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.serial_tx(serial_tx)
	);

endmodule

`default_nettype wire

/* verilog/serial_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_defs.svh"

module serial_tx (
	input  wire                      clk27,
	input  wire                      rst,
	input  wire serial_pkg::char_t   tx_char,
	input  wire                      tx_req,
	output logic                     tx_ack,
	output logic                     serial_tx
);

	serial_pkg::line_state_e state;
	serial_pkg::tick_cnt_t tick_cnt;
	serial_pkg::os_cnt_t os_cnt;
	serial_pkg::bit_idx_t bit_idx;
	serial_pkg::char_t shift;
	logic par_bit;
	logic tick;
	logic bit_end;
	logic start;

	// new request while idle
	assign start = (state == serial_pkg::line_idle) && tx_req && !tx_ack;

	// --------------------
	// bit timing
	// --------------------
	// 15 clocks per tick, 16 ticks per bit
	assign tick = (tick_cnt == `SERIAL_CLKS_PER_TICK - 1);
	assign bit_end = tick && (os_cnt == `SERIAL_OVERSAMPLE - 1);

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			tick_cnt <= '0;
			os_cnt <= '0;
		end else if (state == serial_pkg::line_idle) begin
			tick_cnt <= '0;
			os_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
			os_cnt <= os_cnt + 4'd1;
		end else begin
			tick_cnt <= tick_cnt + 4'd1;
		end
	end

	// --------------------
	// frame sequencer
	// --------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= serial_pkg::line_idle;
			bit_idx <= '0;
			tx_ack <= 1'b0;
			serial_tx <= 1'b1;
		end else begin
			unique case (state)
				serial_pkg::line_idle: begin
					serial_tx <= 1'b1;
					if (tx_ack && !tx_req) begin
						tx_ack <= 1'b0;
					end
					if (start) begin
						serial_tx <= 1'b0;
						state <= serial_pkg::line_start;
					end
				end
				serial_pkg::line_start: begin
					if (bit_end) begin
						serial_tx <= shift[0];
						bit_idx <= '0;
						state <= serial_pkg::line_data;
					end
				end
				serial_pkg::line_data: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == `SERIAL_BITS - 1) begin
							serial_tx <= par_bit;
							state <= serial_pkg::line_parity;
						end else begin
							serial_tx <= shift[0];
						end
					end
				end
				serial_pkg::line_parity: begin
					if (bit_end) begin
						serial_tx <= 1'b1;
						state <= serial_pkg::line_stop;
					end
				end
				serial_pkg::line_stop: begin
					// ack once the stop bit is over
					if (bit_end) begin
						tx_ack <= 1'b1;
						state <= serial_pkg::line_idle;
					end
				end
				default: state <= serial_pkg::line_idle;
			endcase
		end
	end

	// data shifter, lsb goes out first
	always_ff @(posedge clk27) begin
		if (start) begin
			shift <= tx_char;
			par_bit <= (^tx_char) ^ `SERIAL_PARITY_ODD;
		end else if (bit_end && (state == serial_pkg::line_start || state == serial_pkg::line_data)) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

/* verilog/echo_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_defs.svh"

module echo_formatter (
	input  wire                      clk27,
	input  wire                      rst,
	input  wire serial_pkg::char_t   rx_char,
	input  wire                      rx_req,
	output logic                     rx_ack,
	output serial_pkg::char_t        tx_char,
	output logic                     tx_req,
	input  wire                      tx_ack
);

	echo_pkg::echo_state_e state;
	echo_pkg::echo_state_e after_state;
	echo_pkg::digit_idx_t digit;
	serial_pkg::char_t char_q;
	serial_pkg::char_t next_char;
	logic tx_done;
	logic tx_free;
	logic take_char;

	// tx handshake phases
	assign tx_done = tx_req && tx_ack;
	assign tx_free = !tx_req && !tx_ack;
	assign take_char = (state == echo_pkg::wait_char) && rx_req && !rx_ack;

	// --------------------
	// output character
	// --------------------
	always_comb begin
		next_char = char_q;
		after_state = echo_pkg::wait_char;
		unique case (state)
			echo_pkg::send_char: begin
				next_char = char_q;
				after_state = echo_pkg::send_space;
			end
			echo_pkg::send_space: begin
				next_char = `SERIAL_ASCII_SPACE;
				after_state = echo_pkg::send_bit;
			end
			echo_pkg::send_bit: begin
				// msb first
				next_char = char_q[digit] ? `SERIAL_ASCII_ONE : `SERIAL_ASCII_ZERO;
				after_state = (digit == '0) ? echo_pkg::send_cr : echo_pkg::send_bit;
			end
			echo_pkg::send_cr: begin
				next_char = `SERIAL_ASCII_CR;
				after_state = echo_pkg::send_lf;
			end
			echo_pkg::send_lf: begin
				next_char = `SERIAL_ASCII_LF;
				after_state = echo_pkg::wait_char;
			end
			default: begin
				next_char = char_q;
				after_state = echo_pkg::wait_char;
			end
		endcase
	end

	// --------------------
	// sequencer
	// --------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= echo_pkg::wait_char;
			digit <= '1;
			rx_ack <= 1'b0;
			tx_req <= 1'b0;
		end else begin
			// rx side finishes its own four-phase cycle
			if (rx_ack && !rx_req) begin
				rx_ack <= 1'b0;
			end
			if (state == echo_pkg::wait_char) begin
				if (take_char) begin
					rx_ack <= 1'b1;
					state <= echo_pkg::send_char;
				end
			end else if (tx_free) begin
				tx_req <= 1'b1;
			end else if (tx_done) begin
				tx_req <= 1'b0;
				state <= after_state;
				// wraps back to 7 after the last digit
				if (state == echo_pkg::send_bit) begin
					digit <= digit - 3'd1;
				end
			end
		end
	end

	// latched char and tx data register
	always_ff @(posedge clk27) begin
		if (take_char) begin
			char_q <= rx_char;
		end
		if (state != echo_pkg::wait_char && tx_free) begin
			tx_char <= next_char;
		end
	end

endmodule

`default_nettype wire

/* verilog/serial_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "serial_defs.svh"

module serial_rx (
	input  wire                clk27,
	input  wire                rst,
	input  wire                serial_rx,
	output serial_pkg::char_t  rx_char,
	output logic               rx_req,
	input  wire                rx_ack,
	output logic               parity_error,
	output logic               overrun
);

	logic [1:0] line_sync;
	logic line_in;
	serial_pkg::line_state_e state;
	serial_pkg::tick_cnt_t tick_cnt;
	serial_pkg::os_cnt_t os_cnt;
	serial_pkg::bit_idx_t bit_idx;
	serial_pkg::char_t shift;
	logic par_bit;
	logic tick;
	logic sample;
	logic parity_ok;
	logic frame_done;
	logic frame_good;
	logic busy;

	// --------------------
	// line input
	// --------------------
	// two flop synchronizer, idle high
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			line_sync <= 2'b11;
		end else begin
			line_sync <= {line_sync[0], serial_rx};
		end
	end

	assign line_in = line_sync[1];

	// --------------------
	// bit timing
	// --------------------
	assign tick = (tick_cnt == `SERIAL_CLKS_PER_TICK - 1);
	// os_cnt wraps every bit, so this hits mid-bit each time
	assign sample = tick && (os_cnt == `SERIAL_SAMPLE_TICK - 1);

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			tick_cnt <= '0;
			os_cnt <= '0;
		end else if (state == serial_pkg::line_idle) begin
			// aligned to the detected start edge
			tick_cnt <= '0;
			os_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
			os_cnt <= os_cnt + 4'd1;
		end else begin
			tick_cnt <= tick_cnt + 4'd1;
		end
	end

	// --------------------
	// frame checks
	// --------------------
	// data plus parity must xor to the parity mode
	assign parity_ok = (((^shift) ^ par_bit) == `SERIAL_PARITY_ODD);
	assign frame_done = sample && (state == serial_pkg::line_stop);
	assign frame_good = frame_done && parity_ok && line_in;
	// previous char still in its handshake
	assign busy = rx_req || rx_ack;

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= serial_pkg::line_idle;
			bit_idx <= '0;
			rx_req <= 1'b0;
			parity_error <= 1'b0;
			overrun <= 1'b0;
		end else begin
			// ack seen, release request
			if (rx_req && rx_ack) begin
				rx_req <= 1'b0;
			end
			unique case (state)
				serial_pkg::line_idle: begin
					if (!line_in) begin
						state <= serial_pkg::line_start;
					end
				end
				serial_pkg::line_start: begin
					if (sample) begin
						// glitch if line went high again
						state <= line_in ? serial_pkg::line_idle : serial_pkg::line_data;
						bit_idx <= '0;
					end
				end
				serial_pkg::line_data: begin
					if (sample) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == `SERIAL_BITS - 1) begin
							state <= serial_pkg::line_parity;
						end
					end
				end
				serial_pkg::line_parity: begin
					if (sample) begin
						state <= serial_pkg::line_stop;
					end
				end
				serial_pkg::line_stop: begin
					if (sample) begin
						state <= serial_pkg::line_idle;
						if (!parity_ok) begin
							parity_error <= 1'b1;
						end else if (frame_good && busy) begin
							overrun <= 1'b1;
						end else if (frame_good) begin
							rx_req <= 1'b1;
						end
					end
				end
				default: state <= serial_pkg::line_idle;
			endcase
		end
	end

	// shift register and holding register
	always_ff @(posedge clk27) begin
		if (sample && state == serial_pkg::line_data) begin
			// lsb first, fills from the top
			shift <= {line_in, shift[`SERIAL_BITS-1:1]};
		end
		if (sample && state == serial_pkg::line_parity) begin
			par_bit <= line_in;
		end
		if (frame_good && !busy) begin
			rx_char <= shift;
		end
	end

endmodule

`default_nettype wire

/* verilog/echo_pkg.sv */
`default_nettype none

package echo_pkg;

	// --------------------
	// echo line sequencer
	// --------------------

	// char, space, 8 digits, cr, lf
	typedef enum logic [2:0] {
		wait_char,
		send_char,
		send_space,
		send_bit,
		send_cr,
		send_lf
	} echo_state_e;

	// binary digit being printed, msb first
	typedef logic [2:0] digit_idx_t;

endpackage

`default_nettype wire

/* verilog/serial_pkg.sv */
`default_nettype none

`include "serial_defs.svh"

package serial_pkg;

	// one character on the line
	typedef logic [`SERIAL_BITS-1:0] char_t;

	// clocks within one oversampling tick
	typedef logic [3:0] tick_cnt_t;

	// ticks within one bit
	typedef logic [3:0] os_cnt_t;

	// data bit position
	typedef logic [2:0] bit_idx_t;

	// frame phase, shared by rx and tx
	typedef enum logic [2:0] {
		line_idle,
		line_start,
		line_data,
		line_parity,
		line_stop
	} line_state_e;

endpackage

`default_nettype wire

/* verilog/serial_defs.svh */
`ifndef SERIAL_DEFS_SVH
`define SERIAL_DEFS_SVH

// line timing
`define SERIAL_MAIN_CLK_HZ     27_000_000
`define SERIAL_BAUD            112_500
`define SERIAL_OVERSAMPLE      16
// 27 MHz / (112500 * 16), exact
`define SERIAL_CLKS_PER_TICK   (`SERIAL_MAIN_CLK_HZ / (`SERIAL_BAUD * `SERIAL_OVERSAMPLE))
// mid-bit sample point in ticks
`define SERIAL_SAMPLE_TICK     8

// character format
`define SERIAL_BITS            8
// 0 selects even parity
`define SERIAL_PARITY_ODD      1'b0

// echo line characters
`define SERIAL_ASCII_SPACE     8'h20
`define SERIAL_ASCII_CR        8'h0d
`define SERIAL_ASCII_LF        8'h0a
`define SERIAL_ASCII_ZERO      8'h30
`define SERIAL_ASCII_ONE       8'h31

`endif
